/* Makefile */
# Verilator build and run for the system control core testbench

VERILATOR ?= verilator
TOP       ?= sys_ctrl_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rtl/exec_monitor.sv */
// Security monitor that raises a sticky forced trap on illegal CPU accesses
`timescale 1ns/1ps
`default_nettype none

module exec_monitor import sys_ctrl_pkg::*; (
  input  wire           clk,
  input  wire           reset_n,
  input  wire cpu_bus_t cpu_bus,
  input  wire mon_cfg_t mon_cfg,
  output logic          force_trap
);

  logic ram_oob;        // Beyond the physical RAM
  logic fw_exec;
  logic mon_exec;
  logic trap_set;

  // ----------------------------------------------------------
  // Violation checks
  // ----------------------------------------------------------
  always_comb begin
    ram_oob  = (cpu_bus.addr[31:30] == 2'b01) && (|cpu_bus.addr[29:17]);

    fw_exec  = cpu_bus.instr &&
               (cpu_bus.addr >= FW_RAM_FIRST) &&
               (cpu_bus.addr <= FW_RAM_LAST);

    // Data-only window, active once enabled
    mon_exec = cpu_bus.instr && mon_cfg.en &&
               (cpu_bus.addr >= mon_cfg.first) &&
               (cpu_bus.addr <= mon_cfg.last);

    trap_set = cpu_bus.valid && (ram_oob || fw_exec || mon_exec);
  end

  // Sticky flag
  always_ff @(posedge clk) begin
    if (!reset_n)
      force_trap <= 1'b0;
    else if (trap_set)
      force_trap <= 1'b1;
  end

endmodule

`default_nettype wire

/* rtl/spi_master.sv */
// Mode-0 byte-wide SPI master driven by enable, data and start strobes
`timescale 1ns/1ps
`default_nettype none

module spi_master import sys_ctrl_pkg::*; (
  input  wire            clk,
  input  wire            reset_n,
  input  wire spi_ctrl_t spi_ctrl,
  output spi_stat_t      spi_stat,
  output logic           spi_ss,
  output logic           spi_sck,
  output logic           spi_mosi,
  input  wire            spi_miso
);

  typedef enum logic {
    IDLE,
    SHIFT
  } state_e;

  state_e     state;
  logic       enable_reg;
  logic       ready_reg;
  logic [2:0] bit_ctr;
  spi_byte_t  tx_shift;
  spi_byte_t  rx_shift;

  assign spi_ss           = !enable_reg;     // Active low select
  assign spi_stat.ready   = ready_reg;
  assign spi_stat.rx_data = rx_shift;

  // ----------------------------------------------------------
  // Control and clock generation
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state      <= IDLE;
      enable_reg <= 1'b0;
      ready_reg  <= 1'b1;
      bit_ctr    <= '0;
      spi_sck    <= 1'b0;
      spi_mosi   <= 1'b0;
    end else begin
      if (spi_ctrl.enable_vld)
        enable_reg <= spi_ctrl.enable;

      case (state)
        IDLE: begin
          if (spi_ctrl.start) begin
            state     <= SHIFT;
            ready_reg <= 1'b0;
            bit_ctr   <= '0;
            spi_mosi  <= tx_shift[7];    // MSB ahead of first rising edge
          end
        end

        SHIFT: begin
          spi_sck <= !spi_sck;
          if (spi_sck) begin
            // Falling edge
            if (bit_ctr == 3'd7) begin
              state     <= IDLE;
              ready_reg <= 1'b1;
            end else begin
              bit_ctr  <= bit_ctr + 1'b1;
              spi_mosi <= tx_shift[6];
            end
          end
        end

        default: state <= IDLE;
      endcase
    end
  end

  // ----------------------------------------------------------
  // Data shift registers
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (state == IDLE) begin
      if (spi_ctrl.tx_data_vld)
        tx_shift <= spi_ctrl.tx_data;
    end else if (spi_sck) begin
      tx_shift <= {tx_shift[6:0], 1'b0};
    end else begin
      rx_shift <= {rx_shift[6:0], spi_miso};   // Sample on rising edge
    end
  end

endmodule

`default_nettype wire

/* rtl/sys_ctrl.sv */
// System control core top joining register bank, monitor, trap LEDs and SPI
`timescale 1ns/1ps
`default_nettype none

module sys_ctrl import sys_ctrl_pkg::*; (
  input  wire            clk,
  input  wire            reset_n,

  input  wire            cpu_trap,
  output logic           fw_app_mode,

  input  wire word_t     cpu_addr,
  input  wire            cpu_instr,
  input  wire            cpu_valid,
  output logic           force_trap,

  output ram_addr_key_t  ram_addr_rand,
  output word_t          ram_data_rand,

  output logic           spi_ss,
  output logic           spi_sck,
  output logic           spi_mosi,
  input  wire            spi_miso,

  output logic           led_r,
  output logic           led_g,
  output logic           led_b,

  input  wire            gpio1,
  input  wire            gpio2,
  output logic           gpio3,
  output logic           gpio4,

  input  wire            cs,
  input  wire            we,
  input  wire reg_addr_t address,
  input  wire word_t     write_data,
  output word_t          read_data,
  output logic           ready
);

  cpu_bus_t  cpu_bus;
  mon_cfg_t  mon_cfg;
  spi_ctrl_t spi_ctrl;
  spi_stat_t spi_stat;
  led_t      led_reg;
  led_t      led;

  assign cpu_bus.addr  = cpu_addr;
  assign cpu_bus.instr = cpu_instr;
  assign cpu_bus.valid = cpu_valid;

  // Plain LED levels
  assign led_r = led[2];
  assign led_g = led[1];
  assign led_b = led[0];

  sys_regs regs (
    .clk           (clk),
    .reset_n       (reset_n),
    .cs            (cs),
    .we            (we),
    .address       (address),
    .write_data    (write_data),
    .read_data     (read_data),
    .ready         (ready),
    .gpio1         (gpio1),
    .gpio2         (gpio2),
    .gpio3         (gpio3),
    .gpio4         (gpio4),
    .led_reg       (led_reg),
    .fw_app_mode   (fw_app_mode),
    .ram_addr_rand (ram_addr_rand),
    .ram_data_rand (ram_data_rand),
    .mon_cfg       (mon_cfg),
    .spi_ctrl      (spi_ctrl),
    .spi_stat      (spi_stat)
  );

  exec_monitor monitor (
    .clk        (clk),
    .reset_n    (reset_n),
    .cpu_bus    (cpu_bus),
    .mon_cfg    (mon_cfg),
    .force_trap (force_trap)
  );

  trap_blinker blinker (
    .clk      (clk),
    .reset_n  (reset_n),
    .cpu_trap (cpu_trap),
    .led_reg  (led_reg),
    .led      (led)
  );

  spi_master spi (
    .clk      (clk),
    .reset_n  (reset_n),
    .spi_ctrl (spi_ctrl),
    .spi_stat (spi_stat),
    .spi_ss   (spi_ss),
    .spi_sck  (spi_sck),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso)
  );

endmodule

`default_nettype wire

/* rtl/sys_ctrl_pkg.sv */
// System control package with the register map, identity constants and bus types
`default_nettype none

package sys_ctrl_pkg;

  // ----------------------------------------------------------
  // Widths with a meaning
  // ----------------------------------------------------------
  typedef logic [7:0]  reg_addr_t;
  typedef logic [31:0] word_t;
  typedef logic [2:0]  led_t;           // Red 2, green 1, blue 0
  typedef logic [14:0] ram_addr_key_t;
  typedef logic [23:0] blink_ctr_t;
  typedef logic [7:0]  spi_byte_t;

  // ----------------------------------------------------------
  // Grouped signals
  // ----------------------------------------------------------
  typedef struct packed {
    word_t addr;
    logic  instr;                       // Instruction fetch
    logic  valid;
  } cpu_bus_t;

  typedef struct packed {
    logic  en;
    word_t first;
    word_t last;
  } mon_cfg_t;

  typedef struct packed {
    logic      enable;
    logic      enable_vld;
    logic      start;
    spi_byte_t tx_data;
    logic      tx_data_vld;
  } spi_ctrl_t;

  typedef struct packed {
    logic      ready;
    spi_byte_t rx_data;
  } spi_stat_t;

  // ----------------------------------------------------------
  // Register map
  // ----------------------------------------------------------
  localparam reg_addr_t ADDR_NAME0         = 8'h00;
  localparam reg_addr_t ADDR_NAME1         = 8'h01;
  localparam reg_addr_t ADDR_VERSION       = 8'h02;
  localparam reg_addr_t ADDR_SWITCH_APP    = 8'h08;
  localparam reg_addr_t ADDR_LED           = 8'h09;
  localparam reg_addr_t ADDR_GPIO          = 8'h0a;
  localparam reg_addr_t ADDR_APP_START     = 8'h0c;
  localparam reg_addr_t ADDR_APP_SIZE      = 8'h0d;
  localparam reg_addr_t ADDR_BLAKE2S       = 8'h10;
  localparam reg_addr_t ADDR_CDI_FIRST     = 8'h20;
  localparam reg_addr_t ADDR_CDI_LAST      = 8'h27;
  localparam reg_addr_t ADDR_UDI_FIRST     = 8'h30;
  localparam reg_addr_t ADDR_UDI_LAST      = 8'h31;
  localparam reg_addr_t ADDR_RAM_ADDR_RAND = 8'h40;
  localparam reg_addr_t ADDR_RAM_DATA_RAND = 8'h41;
  localparam reg_addr_t ADDR_CPU_MON_CTRL  = 8'h60;
  localparam reg_addr_t ADDR_CPU_MON_FIRST = 8'h61;
  localparam reg_addr_t ADDR_CPU_MON_LAST  = 8'h62;
  localparam reg_addr_t ADDR_SPI_EN        = 8'h80;
  localparam reg_addr_t ADDR_SPI_XFER      = 8'h81;
  localparam reg_addr_t ADDR_SPI_DATA      = 8'h82;

  // Identity and device words
  localparam word_t CORE_NAME0   = 32'h73797320;  // "sys "
  localparam word_t CORE_NAME1   = 32'h6374726c;  // "ctrl"
  localparam word_t CORE_VERSION = 32'h00000005;
  localparam word_t UDI_WORD0    = 32'h00010203;
  localparam word_t UDI_WORD1    = 32'h04050607;

  // Firmware RAM, never executable
  localparam word_t FW_RAM_FIRST = 32'hd0000000;
  localparam word_t FW_RAM_LAST  = 32'hd00007ff;

  localparam led_t LED_RESET = 3'd6;

  // GPIO register bits
  localparam int GPIO1_BIT = 0;
  localparam int GPIO2_BIT = 1;
  localparam int GPIO3_BIT = 2;
  localparam int GPIO4_BIT = 3;

endpackage

`default_nettype wire

/* rtl/sys_regs.sv */
// Register bank with lockable application setup, CDI memory, GPIO and SPI access
`timescale 1ns/1ps
`default_nettype none

module sys_regs import sys_ctrl_pkg::*; (
  input  wire            clk,
  input  wire            reset_n,
  input  wire            cs,
  input  wire            we,
  input  wire reg_addr_t address,
  input  wire word_t     write_data,
  output word_t          read_data,
  output logic           ready,
  input  wire            gpio1,
  input  wire            gpio2,
  output logic           gpio3,
  output logic           gpio4,
  output led_t           led_reg,
  output logic           fw_app_mode,
  output ram_addr_key_t  ram_addr_rand,
  output word_t          ram_data_rand,
  output mon_cfg_t       mon_cfg,
  output spi_ctrl_t      spi_ctrl,
  input  wire spi_stat_t spi_stat
);

  word_t      cdi_mem [8];
  word_t      app_start_reg;
  word_t      app_size_reg;
  word_t      blake2s_reg;
  logic [1:0] gpio1_sync;
  logic [1:0] gpio2_sync;

  logic switch_app_we;
  logic led_we;
  logic gpio_we;
  logic app_start_we;
  logic app_size_we;
  logic blake2s_we;
  logic cdi_we;
  logic ram_addr_we;
  logic ram_data_we;
  logic mon_en_we;
  logic mon_first_we;
  logic mon_last_we;

  assign ready = cs;

  // ----------------------------------------------------------
  // Write decode under the lock rules
  // ----------------------------------------------------------
  always_comb begin
    switch_app_we = 1'b0;
    led_we        = 1'b0;
    gpio_we       = 1'b0;
    app_start_we  = 1'b0;
    app_size_we   = 1'b0;
    blake2s_we    = 1'b0;
    cdi_we        = 1'b0;
    ram_addr_we   = 1'b0;
    ram_data_we   = 1'b0;
    mon_en_we     = 1'b0;
    mon_first_we  = 1'b0;
    mon_last_we   = 1'b0;
    spi_ctrl      = '0;
    spi_ctrl.enable  = write_data[0];
    spi_ctrl.tx_data = write_data[7:0];

    if (cs && we) begin
      case (address) inside
        ADDR_SWITCH_APP:                 switch_app_we = 1'b1;
        ADDR_LED:                        led_we        = 1'b1;
        ADDR_GPIO:                       gpio_we       = 1'b1;
        ADDR_APP_START:                  app_start_we  = !fw_app_mode;
        ADDR_APP_SIZE:                   app_size_we   = !fw_app_mode;
        ADDR_BLAKE2S:                    blake2s_we    = !fw_app_mode;
        [ADDR_CDI_FIRST:ADDR_CDI_LAST]:  cdi_we        = !fw_app_mode;
        ADDR_RAM_ADDR_RAND:              ram_addr_we   = !fw_app_mode;
        ADDR_RAM_DATA_RAND:              ram_data_we   = !fw_app_mode;
        ADDR_CPU_MON_CTRL:               mon_en_we     = 1'b1;
        ADDR_CPU_MON_FIRST:              mon_first_we  = !mon_cfg.en;
        ADDR_CPU_MON_LAST:               mon_last_we   = !mon_cfg.en;
        ADDR_SPI_EN:                     spi_ctrl.enable_vld  = 1'b1;
        ADDR_SPI_XFER:                   spi_ctrl.start       = 1'b1;
        ADDR_SPI_DATA:                   spi_ctrl.tx_data_vld = 1'b1;
        default: ;
      endcase
    end
  end

  // ----------------------------------------------------------
  // Control registers
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      fw_app_mode <= 1'b0;
      led_reg     <= LED_RESET;
      gpio3       <= 1'b0;
      gpio4       <= 1'b0;
      mon_cfg     <= '0;
    end else begin
      if (switch_app_we)
        fw_app_mode <= 1'b1;        // Sticky until reset
      if (led_we)
        led_reg <= write_data[2:0];
      if (gpio_we) begin
        gpio3 <= write_data[GPIO3_BIT];
        gpio4 <= write_data[GPIO4_BIT];
      end
      if (mon_en_we)
        mon_cfg.en <= 1'b1;
      if (mon_first_we)
        mon_cfg.first <= write_data;
      if (mon_last_we)
        mon_cfg.last <= write_data;
    end
  end

  // Application setup, keys, CDI and input synchronisers
  always_ff @(posedge clk) begin
    gpio1_sync <= {gpio1_sync[0], gpio1};
    gpio2_sync <= {gpio2_sync[0], gpio2};
    if (app_start_we)
      app_start_reg <= write_data;
    if (app_size_we)
      app_size_reg <= write_data;
    if (blake2s_we)
      blake2s_reg <= write_data;
    if (cdi_we)
      cdi_mem[address[2:0]] <= write_data;
    if (ram_addr_we)
      ram_addr_rand <= write_data[14:0];
    if (ram_data_we)
      ram_data_rand <= write_data;
  end

  // ----------------------------------------------------------
  // Read mux
  // ----------------------------------------------------------
  always_comb begin
    read_data = '0;
    if (cs && !we) begin
      case (address) inside
        ADDR_NAME0:      read_data = CORE_NAME0;
        ADDR_NAME1:      read_data = CORE_NAME1;
        ADDR_VERSION:    read_data = CORE_VERSION;
        ADDR_SWITCH_APP: read_data = {32{fw_app_mode}};
        ADDR_LED:        read_data = {29'h0, led_reg};
        ADDR_GPIO: begin
          read_data[GPIO1_BIT] = gpio1_sync[1];
          read_data[GPIO2_BIT] = gpio2_sync[1];
          read_data[GPIO3_BIT] = gpio3;
          read_data[GPIO4_BIT] = gpio4;
        end
        ADDR_APP_START:                 read_data = app_start_reg;
        ADDR_APP_SIZE:                  read_data = app_size_reg;
        ADDR_BLAKE2S:                   read_data = blake2s_reg;
        [ADDR_CDI_FIRST:ADDR_CDI_LAST]: read_data = cdi_mem[address[2:0]];
        [ADDR_UDI_FIRST:ADDR_UDI_LAST]: begin
          if (!fw_app_mode)               // Hidden from the application
            read_data = address[0] ? UDI_WORD1 : UDI_WORD0;
        end
        ADDR_SPI_XFER: read_data[0]   = spi_stat.ready;
        ADDR_SPI_DATA: read_data[7:0] = spi_stat.rx_data;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/trap_blinker.sv */
// Trap indicator that overrides the LEDs with a blinking red pattern
`timescale 1ns/1ps
`default_nettype none

module trap_blinker import sys_ctrl_pkg::*; (
  input  wire       clk,
  input  wire       reset_n,
  input  wire       cpu_trap,
  input  wire led_t led_reg,
  output led_t      led
);

  blink_ctr_t blink_ctr;
  led_t       trap_led;

  // Counter wraps freely, red flips on each zero
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      blink_ctr <= '0;
      trap_led  <= '0;
    end else begin
      blink_ctr <= blink_ctr + 1'b1;
      if (blink_ctr == '0)
        trap_led <= trap_led ^ 3'b100;
    end
  end

  assign led = cpu_trap ? trap_led : led_reg;   // Trap pattern wins

endmodule

`default_nettype wire

/* sim.f */
rtl/sys_ctrl_pkg.sv
rtl/sys_regs.sv
rtl/exec_monitor.sv
rtl/trap_blinker.sv
rtl/spi_master.sv
rtl/sys_ctrl.sv
verification/sys_ctrl_tb.sv

/* verification/sys_ctrl_tb.sv */
// Table-driven testbench for the system control core with register, monitor and SPI checks
`timescale 1ns/1ps
`default_nettype none

module sys_ctrl_tb import sys_ctrl_pkg::*; ();

  localparam int SPI_BYTES = 4;
  localparam int NAME_W    = 8 * 12;

  typedef struct packed {
    logic [NAME_W-1:0] name;
    logic              wr;
    reg_addr_t         addr;
    word_t             wdata;
    word_t             exp;
  } reg_row_t;

  typedef struct packed {
    logic [NAME_W-1:0] name;
    logic              mon_en;
    logic              relock;          // Try to move the window once enabled
    word_t             first;
    word_t             last;
    word_t             addr;
    logic              instr;
    logic              valid;
    logic              trap;
  } mon_row_t;

  logic          clk        = 1'b0;
  logic          reset_n    = 1'b0;
  logic          cpu_trap   = 1'b0;
  word_t         cpu_addr   = '0;
  logic          cpu_instr  = 1'b0;
  logic          cpu_valid  = 1'b0;
  logic          gpio1      = 1'b0;
  logic          gpio2      = 1'b0;
  logic          cs         = 1'b0;
  logic          we         = 1'b0;
  reg_addr_t     address    = '0;
  word_t         write_data = '0;
  wire           spi_miso;
  logic          fw_app_mode;
  logic          force_trap;
  ram_addr_key_t ram_addr_rand;
  word_t         ram_data_rand;
  logic          spi_ss;
  logic          spi_sck;
  logic          spi_mosi;
  logic          led_r;
  logic          led_g;
  logic          led_b;
  logic          gpio3;
  logic          gpio4;
  word_t         read_data;
  logic          ready;

  reg_row_t reg_rows[$];
  mon_row_t mon_rows[$];
  logic     tables_ready = 1'b0;
  int       error_count  = 0;
  int       sck_rises    = 0;

  assign spi_miso = spi_mosi;   // Loopback

  always #4 clk = ~clk;

  always @(posedge spi_sck)
    sck_rises <= sck_rises + 1;

  sys_ctrl uut (.*);

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  task automatic report_failure(input string msg);
    error_count++;
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp)
      report_failure($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_led(input string name, input led_t exp, input led_t act);
    if (act !== exp)
      report_failure($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic check_byte(input string name, input spi_byte_t exp, input spi_byte_t act);
    if (act !== exp)
      report_failure($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      report_failure($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // ----------------------------------------------------------
  // Bus and reset sequences
  // ----------------------------------------------------------
  task automatic apply_reset();
    @(posedge clk);
    reset_n   <= 1'b0;
    cs        <= 1'b0;
    we        <= 1'b0;
    cpu_valid <= 1'b0;
    cpu_instr <= 1'b0;
    repeat (4) @(posedge clk);
    reset_n <= 1'b1;
  endtask

  task automatic bus_write(input reg_addr_t a, input word_t d);
    @(posedge clk);
    cs         <= 1'b1;
    we         <= 1'b1;
    address    <= a;
    write_data <= d;
  endtask

  task automatic bus_idle(input int n);
    repeat (n) begin
      @(posedge clk);
      cs <= 1'b0;
      we <= 1'b0;
    end
  endtask

  // Combinational read data is sampled mid-cycle
  task automatic bus_read_value(input reg_addr_t a, output word_t d);
    @(posedge clk);
    cs         <= 1'b1;
    we         <= 1'b0;
    address    <= a;
    write_data <= '0;
    @(negedge clk);
    check_bit("ready", 1'b1, ready);
    d = read_data;
  endtask

  task automatic apply_reg_row(input reg_row_t r);
    word_t d;
    if (r.wr) begin
      bus_write(r.addr, r.wdata);
    end else begin
      bus_read_value(r.addr, d);
      check_word(string'(r.name), r.exp, d);
    end
  endtask

  task automatic run_mon_row(input mon_row_t r);
    apply_reset();
    bus_write(ADDR_CPU_MON_FIRST, r.first);
    bus_write(ADDR_CPU_MON_LAST, r.last);
    if (r.mon_en) begin
      bus_write(ADDR_CPU_MON_CTRL, 32'h1);
      if (r.relock) begin
        bus_write(ADDR_CPU_MON_FIRST, 32'h4000_0000);
        bus_write(ADDR_CPU_MON_LAST, 32'h4000_ffff);
      end
    end
    @(posedge clk);
    cs        <= 1'b0;
    we        <= 1'b0;
    cpu_addr  <= r.addr;
    cpu_instr <= r.instr;
    cpu_valid <= r.valid;
    @(posedge clk);
    cpu_valid <= 1'b0;
    cpu_instr <= 1'b0;
    @(negedge clk);                     // Flag lands one cycle after the access
    check_bit(string'(r.name), r.trap, force_trap);
  endtask

  // ----------------------------------------------------------
  // Stimulus tables
  // ----------------------------------------------------------
  task automatic add_read_row(input logic [NAME_W-1:0] n, input reg_addr_t a, input word_t e);
    reg_rows.push_back('{n, 1'b0, a, 32'h0, e});
  endtask

  task automatic add_write_row(input logic [NAME_W-1:0] n, input reg_addr_t a, input word_t d);
    reg_rows.push_back('{n, 1'b1, a, d, 32'h0});
  endtask

  task automatic add_mon_row(input logic [NAME_W-1:0] n, input logic en, input logic relock,
                             input word_t first, input word_t last, input word_t a,
                             input logic instr, input logic valid, input logic trap);
    mon_rows.push_back('{n, en, relock, first, last, a, instr, valid, trap});
  endtask

  task automatic build_tables();
    add_read_row("name0", ADDR_NAME0, CORE_NAME0);
    add_read_row("name1", ADDR_NAME1, CORE_NAME1);
    add_read_row("version", ADDR_VERSION, CORE_VERSION);
    add_read_row("led_reset", ADDR_LED, 32'(LED_RESET));
    add_read_row("switch_rst", ADDR_SWITCH_APP, 32'h0);
    add_read_row("udi0", ADDR_UDI_FIRST, UDI_WORD0);
    add_read_row("udi1", ADDR_UDI_LAST, UDI_WORD1);
    // Setup before the mode switch
    add_write_row("app_start_w", ADDR_APP_START, 32'h0001_0000);
    add_read_row("app_start", ADDR_APP_START, 32'h0001_0000);
    add_write_row("app_size_w", ADDR_APP_SIZE, 32'h0000_4000);
    add_read_row("app_size", ADDR_APP_SIZE, 32'h0000_4000);
    add_write_row("blake2s_w", ADDR_BLAKE2S, 32'h3000_0040);
    add_read_row("blake2s", ADDR_BLAKE2S, 32'h3000_0040);
    add_write_row("cdi0_w", ADDR_CDI_FIRST, 32'ha5a5_0001);
    add_write_row("cdi7_w", ADDR_CDI_LAST, 32'h5a5a_0007);
    add_read_row("cdi0", ADDR_CDI_FIRST, 32'ha5a5_0001);
    add_read_row("cdi7", ADDR_CDI_LAST, 32'h5a5a_0007);
    add_write_row("ram_addr_w", ADDR_RAM_ADDR_RAND, 32'h0000_7abc);
    add_write_row("ram_data_w", ADDR_RAM_DATA_RAND, 32'h1357_9bdf);
    // Mode switch locks the setup
    add_write_row("switch_w", ADDR_SWITCH_APP, 32'h0);
    add_read_row("switch_app", ADDR_SWITCH_APP, 32'hffff_ffff);
    add_write_row("app_start_l", ADDR_APP_START, 32'hdead_0000);
    add_read_row("app_start_k", ADDR_APP_START, 32'h0001_0000);
    add_write_row("app_size_l", ADDR_APP_SIZE, 32'hdead_0001);
    add_read_row("app_size_k", ADDR_APP_SIZE, 32'h0000_4000);
    add_write_row("blake2s_l", ADDR_BLAKE2S, 32'hdead_0002);
    add_read_row("blake2s_k", ADDR_BLAKE2S, 32'h3000_0040);
    add_write_row("cdi0_l", ADDR_CDI_FIRST, 32'hdead_0003);
    add_read_row("cdi0_k", ADDR_CDI_FIRST, 32'ha5a5_0001);
    add_write_row("ram_addr_l", ADDR_RAM_ADDR_RAND, 32'h0000_1111);
    add_write_row("ram_data_l", ADDR_RAM_DATA_RAND, 32'h2222_2222);
    add_read_row("udi0_hidden", ADDR_UDI_FIRST, 32'h0);
    add_read_row("udi1_hidden", ADDR_UDI_LAST, 32'h0);

    add_mon_row("ram_in", 0, 0, 0, 0, 32'h4000_1000, 1'b0, 1'b1, 1'b0);
    add_mon_row("ram_oob", 0, 0, 0, 0, 32'h4002_0000, 1'b0, 1'b1, 1'b1);
    add_mon_row("oob_invalid", 0, 0, 0, 0, 32'h4002_0000, 1'b0, 1'b0, 1'b0);
    add_mon_row("fw_fetch", 0, 0, 0, 0, FW_RAM_FIRST + 32'h100, 1'b1, 1'b1, 1'b1);
    add_mon_row("fw_data", 0, 0, 0, 0, FW_RAM_FIRST + 32'h100, 1'b0, 1'b1, 1'b0);
    add_mon_row("fw_past", 0, 0, 0, 0, FW_RAM_LAST + 32'h1, 1'b1, 1'b1, 1'b0);
    add_mon_row("mon_off", 0, 0, 32'h4000_0100, 32'h4000_01ff, 32'h4000_0180,
                1'b1, 1'b1, 1'b0);
    add_mon_row("mon_in", 1, 0, 32'h4000_0100, 32'h4000_01ff, 32'h4000_0180,
                1'b1, 1'b1, 1'b1);
    add_mon_row("mon_data", 1, 0, 32'h4000_0100, 32'h4000_01ff, 32'h4000_0180,
                1'b0, 1'b1, 1'b0);
    add_mon_row("mon_out", 1, 0, 32'h4000_0100, 32'h4000_01ff, 32'h4000_0200,
                1'b1, 1'b1, 1'b0);
    add_mon_row("mon_locked", 1, 1, 32'h4000_0100, 32'h4000_01ff, 32'h4000_0400,
                1'b1, 1'b1, 1'b0);
  endtask

  // ----------------------------------------------------------
  // Watchdog
  // ----------------------------------------------------------
  initial begin
    int budget;
    wait (tables_ready);
    budget = (reg_rows.size() + mon_rows.size() + SPI_BYTES) * 20;
    repeat (budget) @(posedge clk);
    report_failure($sformatf("Watchdog expired after %0d cycles, the run hung", budget));
  end

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    logic [31:0] seed;
    spi_byte_t   tx_byte;
    word_t       rd;
    int          sck_base;

    build_tables();
    tables_ready = 1'b1;
    apply_reset();

    foreach (reg_rows[i])
      apply_reg_row(reg_rows[i]);
    bus_idle(1);
    @(negedge clk);
    check_bit("ready_idle", 1'b0, ready);
    check_word("rdata_idle", 32'h0, read_data);
    check_bit("fw_app_mode", 1'b1, fw_app_mode);
    check_word("ram_addr_port", 32'h0000_7abc, word_t'(ram_addr_rand));
    check_word("ram_data_port", 32'h1357_9bdf, ram_data_rand);

    // LED and GPIO outputs
    bus_write(ADDR_LED, 32'h3);
    bus_write(ADDR_GPIO, word_t'((1 << GPIO3_BIT) | (1 << GPIO4_BIT)));
    bus_idle(1);
    @(negedge clk);
    check_led("led_out", 3'b011, {led_r, led_g, led_b});
    check_bit("gpio3", 1'b1, gpio3);
    check_bit("gpio4", 1'b1, gpio4);

    // Synchronised GPIO inputs
    @(posedge clk);
    gpio1 <= 1'b1;
    bus_idle(2);
    bus_read_value(ADDR_GPIO, rd);
    check_word("gpio_in1", word_t'((1 << GPIO1_BIT) | (1 << GPIO3_BIT) | (1 << GPIO4_BIT)), rd);
    @(posedge clk);
    cs    <= 1'b0;
    gpio1 <= 1'b0;
    gpio2 <= 1'b1;
    bus_idle(2);
    bus_read_value(ADDR_GPIO, rd);
    check_word("gpio_in2", word_t'((1 << GPIO2_BIT) | (1 << GPIO3_BIT) | (1 << GPIO4_BIT)), rd);

    foreach (mon_rows[i])
      run_mon_row(mon_rows[i]);

    // Trap overrides the LEDs
    bus_write(ADDR_LED, 32'h1);
    @(posedge clk);
    cs       <= 1'b0;
    we       <= 1'b0;
    cpu_trap <= 1'b1;
    @(negedge clk);
    check_led("led_trap", 3'b100, {led_r, led_g, led_b});
    @(posedge clk);
    cpu_trap <= 1'b0;
    @(negedge clk);
    check_led("led_no_trap", 3'b001, {led_r, led_g, led_b});

    // ----------------------------------------------------------
    // SPI loopback
    // ----------------------------------------------------------
    bus_write(ADDR_SPI_EN, 32'h1);
    bus_idle(1);
    @(negedge clk);
    check_bit("spi_ss", 1'b0, spi_ss);
    seed = 32'h4047eb91;
    for (int i = 0; i < SPI_BYTES; i++) begin
      seed    = xorshift32(seed);
      tx_byte = seed[7:0];
      bus_write(ADDR_SPI_DATA, {24'h0, tx_byte});
      sck_base = sck_rises;
      bus_write(ADDR_SPI_XFER, 32'h0);
      do
        bus_read_value(ADDR_SPI_XFER, rd);
      while (rd[0] !== 1'b1);           // Busy until all eight bits shifted
      check_word($sformatf("spi_sck_edges%0d", i), 32'd8, word_t'(sck_rises - sck_base));
      check_bit($sformatf("spi_sck_idle%0d", i), 1'b0, spi_sck);
      bus_read_value(ADDR_SPI_DATA, rd);
      check_byte($sformatf("spi_byte%0d", i), tx_byte, rd[7:0]);
    end
    bus_idle(2);

    if (error_count == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Done: errors found");
      $fatal(1, "Run ended with errors");
    end
  end

endmodule

`default_nettype wire
